/* hw/bridge_ctrl.sv */
`timescale 1ns/100ps

module bridge_ctrl
  import bridge_pkg::*;
(
  input  logic              clk,
  input  logic              ext_rst_b,
  ring_if.ctrl              ring,
  input  core_state_e       core_state,
  input  logic              core_read_q,
  input  logic              core_write_q,
  input  logic [DATA_W-1:0] bus_addr,
  input  logic [DATA_W-1:0] bus_data,
  output cpu_index_u        own_index,
  output logic              core_next_state,
  output logic              core_rst,
  output logic              ext_rst_e,
  output logic              ext_dispatcher_q,
  output logic              disp_online,
  output logic              ext_next_cpu_e,
  output logic              ext_read_q,
  output logic              ext_write_q,
  output logic [DATA_W-1:0] base_addr,
  output logic [DATA_W-1:0] base_addr_data,
  output logic              msg_push,
  output msg_req_t          msg_req
);

  // first active slot, ordinal zero
  localparam logic [DATA_W-1:0] CPU_ACTIVE = {1'b1, {(DATA_W-1){1'b0}}};

  // sequencer finished
  localparam logic [2:0] SEQ_DONE = 3'd5;

  logic [2:0] rst_step;
  logic       from_finish;
  logic       req_seen;
  logic       grant_self;
  logic       read_state;
  logic       write_state;
  logic       core_req;

  assign read_state = core_state inside {ST_READ_COND, ST_READ_SRC1, ST_READ_SRC0,
                                         ST_READ_DST, ST_START_READ_CMD};
  assign write_state = core_state inside {ST_WRITE_REG_IP, ST_WRITE_DST, ST_WRITE_SRC1,
                                          ST_WRITE_SRC0, ST_WRITE_COND};
  assign core_req    = core_read_q | core_write_q;
  assign grant_self  = ring.grant && (ring.index.raw == own_index.raw);

  // bus requests pass only while we own the dispatcher
  assign ext_read_q  = disp_online & read_state & core_read_q;
  assign ext_write_q = disp_online & write_state & core_write_q;

  always_ff @(posedge clk) begin
    // one cycle strobes
    core_next_state <= 1'b0;
    core_rst        <= 1'b0;
    ext_rst_e       <= 1'b0;
    ext_next_cpu_e  <= 1'b0;
    msg_push        <= 1'b0;
    if (ext_rst_b) begin
      rst_step         <= 3'd0;
      from_finish      <= 1'b0;
      req_seen         <= 1'b0;
      disp_online      <= 1'b0;
      ext_dispatcher_q <= 1'b0;
      own_index        <= '0;
    end else if (rst_step != SEQ_DONE) begin
      case (rst_step)
        3'd0: begin
          disp_online      <= 1'b0;
          ext_dispatcher_q <= 1'b0;
          req_seen         <= 1'b0;
          rst_step         <= 3'd1;
        end
        3'd1: begin
          // finished thread keeps its slot, no index fetch
          from_finish <= (core_state == ST_FINISH_END);
          rst_step    <= (core_state == ST_FINISH_END) ? 3'd3 : 3'd2;
        end
        3'd2: begin
          own_index     <= ring.index;
          msg_push      <= 1'b1;
          msg_req.code  <= MSG_RESET;
          msg_req.index <= ring.index;
          rst_step      <= 3'd3;
        end
        3'd3: begin
          core_rst  <= 1'b1;
          ext_rst_e <= ~from_finish;
          rst_step  <= 3'd4;
        end
        default: begin
          ext_dispatcher_q <= 1'b1;
          rst_step         <= SEQ_DONE;
        end
      endcase
    end else begin
      // serve core requests, drop out after the first idle cycle
      if (disp_online) begin
        if (core_req) begin
          ext_next_cpu_e <= 1'b1;
          req_seen       <= 1'b1;
        end else if (req_seen) begin
          disp_online <= 1'b0;
          req_seen    <= 1'b0;
        end
      end
      if (read_state || write_state) begin
        ext_dispatcher_q <= 1'b1;
      end
      if (grant_self) begin
        disp_online <= 1'b1;
        case (core_state)
          ST_WAIT_FOR_START: begin
            base_addr <= bus_addr + HEADER_SPACE;
            // no data segment given, data follows the code
            base_addr_data  <= (bus_data != '0) ? bus_data + HEADER_SPACE
                                                : bus_addr + HEADER_SPACE;
            core_next_state <= 1'b1;
            ext_next_cpu_e  <= 1'b1;
            msg_push        <= 1'b1;
            msg_req.code    <= MSG_START;
            msg_req.index   <= own_index;
          end
          ST_FINISH_BEGIN: begin
            core_next_state <= 1'b1;
            ext_next_cpu_e  <= 1'b1;
            msg_push        <= 1'b1;
            msg_req.code    <= MSG_END;
            msg_req.index   <= own_index;
          end
          default: begin
          end
        endcase
      end
      // index tracking from finished ring transactions
      if (ring.done) begin
        if (ring.index.raw != own_index.raw) begin
          // lower active thread ended, we move down one slot
          if (ring.index.fields.active && own_index.fields.active &&
              (ring.index.raw < own_index.raw) && (ring.msg == MSG_END)) begin
            own_index <= own_index.raw - 1'b1;
          end else if (!ring.index.fields.active && (ring.msg == MSG_START)) begin
            if (own_index.fields.active) begin
              own_index <= own_index.raw + 1'b1;
            end else begin
              own_index <= own_index.raw - 1'b1;
            end
          end
        end else if ((own_index.raw == '0) && (core_state == ST_START_BEGIN) &&
                     (ring.msg == MSG_START)) begin
          own_index <= CPU_ACTIVE;
        end
      end
      // thread gone, give up the slot and redo start-up
      if (!grant_self && (core_state == ST_FINISH_END)) begin
        own_index <= '0;
        rst_step  <= 3'd0;
      end
    end
  end

endmodule

/* hw/bridge_pkg.sv */
package bridge_pkg;

  // address, data and ring index width
  localparam int DATA_W = 32;

  // ring message code width
  localparam int MSG_W = 8;

  // thread header sits in front of code and data
  localparam logic [DATA_W-1:0] HEADER_SPACE = 16;

  // core state codes as seen on the core side
  typedef enum logic [4:0] {
    ST_WAIT_FOR_START = 5'd0,
    ST_START_BEGIN    = 5'd1,
    ST_READ_COND      = 5'd2,
    ST_READ_SRC1      = 5'd3,
    ST_READ_SRC0      = 5'd4,
    ST_READ_DST       = 5'd5,
    ST_START_READ_CMD = 5'd6,
    ST_WRITE_REG_IP   = 5'd7,
    ST_WRITE_DST      = 5'd8,
    ST_WRITE_SRC1     = 5'd9,
    ST_WRITE_SRC0     = 5'd10,
    ST_WRITE_COND     = 5'd11,
    ST_ALU_BEGIN      = 5'd12,
    ST_FINISH_BEGIN   = 5'd13,
    ST_FINISH_END     = 5'd14
  } core_state_e;

  // messages exchanged over the ring
  typedef enum logic [MSG_W-1:0] {
    MSG_VOID  = 8'h00,
    MSG_RESET = 8'h01,
    MSG_START = 8'h02,
    MSG_END   = 8'h03
  } ring_msg_e;

  // ring index word
  // raw view for ordering, fields view for the tracking rules
  typedef union packed {
    logic [DATA_W-1:0] raw;
    struct packed {
      logic              active;
      logic [DATA_W-2:0] ordinal;
    } fields;
  } cpu_index_u;

  // granted index relative to our own
  typedef enum logic [1:0] {
    REL_NONE   = 2'd0,
    REL_LOWER  = 2'd1,
    REL_HIGHER = 2'd2,
    REL_SELF   = 2'd3
  } ind_rel_e;

  // one queued outgoing message
  typedef struct packed {
    ring_msg_e  code;
    cpu_index_u index;
  } msg_req_t;

endpackage

/* hw/bridge_top.sv */
`timescale 1ns/100ps

module bridge_top
  import bridge_pkg::*;
#(
  parameter int CREDITS = 2
) (
  input  logic              clk,
  input  logic              ext_rst_b,
  input  logic              ext_next_cpu_q,
  input  logic              ext_ring_done,
  input  logic [DATA_W-1:0] ext_cpu_index,
  input  logic [MSG_W-1:0]  ext_cpu_msg,
  input  core_state_e       core_state,
  input  logic              core_read_q,
  input  logic              core_write_q,
  input  logic [DATA_W-1:0] bus_addr,
  input  logic [DATA_W-1:0] bus_data,
  input  logic              msg_credit,
  output logic              core_next_state,
  output logic              core_rst,
  output logic              ext_rst_e,
  output logic              ext_dispatcher_q,
  output logic              disp_online,
  output logic              ext_next_cpu_e,
  output logic              ext_read_q,
  output logic              ext_write_q,
  output logic [DATA_W-1:0] base_addr,
  output logic [DATA_W-1:0] base_addr_data,
  output logic              msg_valid,
  output logic [MSG_W-1:0]  msg_code,
  output logic [DATA_W-1:0] msg_index,
  output ind_rel_e          cpu_ind_rel
);

  cpu_index_u own_index;
  logic       msg_push;
  msg_req_t   msg_req;
  ring_msg_e  msg_code_e;

  // registered ring observation
  ring_if u_ring ();

  assign msg_code = msg_code_e;

  ring_snoop u_snoop (
    .clk            (clk),
    .ext_rst_b      (ext_rst_b),
    .ext_next_cpu_q (ext_next_cpu_q),
    .ext_ring_done  (ext_ring_done),
    .ext_cpu_index  (ext_cpu_index),
    .ext_cpu_msg    (ext_cpu_msg),
    .own_index      (own_index),
    .ring           (u_ring.snoop),
    .cpu_ind_rel    (cpu_ind_rel)
  );

  bridge_ctrl u_ctrl (
    .clk              (clk),
    .ext_rst_b        (ext_rst_b),
    .ring             (u_ring.ctrl),
    .core_state       (core_state),
    .core_read_q      (core_read_q),
    .core_write_q     (core_write_q),
    .bus_addr         (bus_addr),
    .bus_data         (bus_data),
    .own_index        (own_index),
    .core_next_state  (core_next_state),
    .core_rst         (core_rst),
    .ext_rst_e        (ext_rst_e),
    .ext_dispatcher_q (ext_dispatcher_q),
    .disp_online      (disp_online),
    .ext_next_cpu_e   (ext_next_cpu_e),
    .ext_read_q       (ext_read_q),
    .ext_write_q      (ext_write_q),
    .base_addr        (base_addr),
    .base_addr_data   (base_addr_data),
    .msg_push         (msg_push),
    .msg_req          (msg_req)
  );

  // outgoing messages under credit control
  msg_sender #(
    .CREDITS (CREDITS)
  ) u_sender (
    .clk        (clk),
    .ext_rst_b  (ext_rst_b),
    .msg_push   (msg_push),
    .msg_req    (msg_req),
    .msg_credit (msg_credit),
    .msg_valid  (msg_valid),
    .msg_code   (msg_code_e),
    .msg_index  (msg_index)
  );

endmodule

/* hw/msg_sender.sv */
`timescale 1ns/100ps

module msg_sender
  import bridge_pkg::*;
#(
  parameter int CREDITS = 2
) (
  input  logic              clk,
  input  logic              ext_rst_b,
  input  logic              msg_push,
  input  msg_req_t          msg_req,
  input  logic              msg_credit,
  output logic              msg_valid,
  output ring_msg_e         msg_code,
  output logic [DATA_W-1:0] msg_index
);

  localparam int DEPTH = 4;
  localparam int CNT_W = $clog2(CREDITS + 1);

  msg_req_t         mem [DEPTH];
  logic [1:0]       wr_ptr;
  logic [1:0]       rd_ptr;
  logic [2:0]       fill;
  logic [CNT_W-1:0] credit_cnt;
  msg_req_t         head;
  logic             send;

  // empty queue hands the incoming message straight through
  assign head = (fill == '0) ? msg_req : mem[rd_ptr];

  // something to send and a credit to spend
  assign send = ((fill != '0) || msg_push) && (credit_cnt != '0);

  // queue storage
  always_ff @(posedge clk) begin
    if (msg_push) begin
      mem[wr_ptr] <= msg_req;
    end
  end

  // pointers, fill level and credits
  always_ff @(posedge clk) begin
    if (ext_rst_b) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      fill       <= '0;
      credit_cnt <= CNT_W'(CREDITS);
    end else begin
      if (msg_push) begin
        wr_ptr <= wr_ptr + 2'd1;
      end
      // bypass still advances rd so both pointers stay paired
      if (send) begin
        rd_ptr <= rd_ptr + 2'd1;
      end
      fill       <= fill + 3'(msg_push) - 3'(send);
      credit_cnt <= credit_cnt - CNT_W'(send) + CNT_W'(msg_credit);
    end
  end

  // outgoing strobe
  always_ff @(posedge clk) begin
    if (ext_rst_b) begin
      msg_valid <= 1'b0;
    end else begin
      msg_valid <= send;
    end
  end

  // outgoing payload
  always_ff @(posedge clk) begin
    if (send) begin
      msg_code  <= head.code;
      msg_index <= head.index.raw;
    end
  end

endmodule

/* hw/ring_if.sv */
`timescale 1ns/100ps

interface ring_if
  import bridge_pkg::*;
();

  // grant seen on the ring, one cycle late
  logic       grant;

  // ring transaction finished
  logic       done;

  // index carried by the ring in that cycle
  cpu_index_u index;

  // message code carried by the ring
  ring_msg_e  msg;

  // input side fills the observation
  modport snoop (
    output grant,
    output done,
    output index,
    output msg
  );

  // processing part only reads it
  modport ctrl (
    input grant,
    input done,
    input index,
    input msg
  );

endinterface

/* hw/ring_snoop.sv */
`timescale 1ns/100ps

module ring_snoop
  import bridge_pkg::*;
(
  input  logic              clk,
  input  logic              ext_rst_b,
  input  logic              ext_next_cpu_q,
  input  logic              ext_ring_done,
  input  logic [DATA_W-1:0] ext_cpu_index,
  input  logic [MSG_W-1:0]  ext_cpu_msg,
  input  cpu_index_u        own_index,
  ring_if.snoop             ring,
  output ind_rel_e          cpu_ind_rel
);

  // ring strobes
  // cleared so nothing fires right after reset
  always_ff @(posedge clk) begin
    if (ext_rst_b) begin
      ring.grant <= 1'b0;
      ring.done  <= 1'b0;
    end else begin
      ring.grant <= ext_next_cpu_q;
      ring.done  <= ext_ring_done;
    end
  end

  // index and message payload
  // only looked at together with a strobe
  always_ff @(posedge clk) begin
    ring.index <= ext_cpu_index;
    ring.msg   <= ring_msg_e'(ext_cpu_msg);
  end

  // grant classification
  // lands in the same edge as the ring register
  always_ff @(posedge clk) begin
    if (ext_rst_b) begin
      cpu_ind_rel <= REL_NONE;
    end else if (ext_next_cpu_q) begin
      // plain unsigned order on the raw word
      if (ext_cpu_index < own_index.raw) begin
        cpu_ind_rel <= REL_LOWER;
      end else if (ext_cpu_index > own_index.raw) begin
        cpu_ind_rel <= REL_HIGHER;
      end else begin
        cpu_ind_rel <= REL_SELF;
      end
    end else if (ext_ring_done) begin
      // transaction over, relation no longer valid
      cpu_ind_rel <= REL_NONE;
    end
  end

endmodule

/* run.sh */
#!/usr/bin/env bash
# compile and run the bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module tb_top -o sim_tb
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation returned status $status"
  exit 1
fi

if grep -q "^Test OK$" <<< "$out"; then
  exit 0
fi
exit 1

/* tb.f */
hw/bridge_pkg.sv
hw/ring_if.sv
hw/ring_snoop.sv
hw/bridge_ctrl.sv
hw/msg_sender.sv
hw/bridge_top.sv
testbench/bridge_sva.sv
testbench/tb_top.sv

/* testbench/bridge_sva.sv */
`timescale 1ns/100ps

module bridge_sva #(
  parameter int CREDITS = 2,
  parameter int CNT_W   = $clog2(CREDITS + 1)
) (
  input logic             clk,
  input logic             ext_rst_b,
  input logic             msg_valid,
  input logic             msg_credit,
  input logic [CNT_W-1:0] credit_cnt
);

  // messages seen on the pins and not yet paid back by a credit pulse
  int in_flight;

  // assertion failures so far
  int fail_cnt = 0;

  always_ff @(posedge clk) begin
    if (ext_rst_b) begin
      in_flight <= 0;
    end else begin
      in_flight <= in_flight + int'(msg_valid) - int'(msg_credit);
    end
  end

  // a message only leaves while the receiver still has room for it
  property valid_needs_credit;
    @(posedge clk) disable iff (ext_rst_b)
      msg_valid |-> (in_flight < CREDITS);
  endproperty

  // returned credits never pile up past the start value
  property credits_bounded;
    @(posedge clk) disable iff (ext_rst_b)
      credit_cnt <= CNT_W'(CREDITS);
  endproperty

  assert property (valid_needs_credit)
    else begin
      $error("msg_valid without a credit");
      fail_cnt++;
    end

  assert property (credits_bounded)
    else begin
      $error("credit count above its limit");
      fail_cnt++;
    end

endmodule

// attached to every sender instance
bind msg_sender bridge_sva #(
  .CREDITS (CREDITS)
) u_sva (
  .clk        (clk),
  .ext_rst_b  (ext_rst_b),
  .msg_valid  (msg_valid),
  .msg_credit (msg_credit),
  .credit_cnt (credit_cnt)
);

/* testbench/tb_top.sv */
`timescale 1ns/100ps

module tb_top
  import bridge_pkg::*;
();

  // rough length of all tests in cycles, plus slack
  localparam int TEST_CYCLES = 260;
  localparam int MARGIN      = 200;
  localparam int MSG_WAIT    = 20;

  logic              clk;
  logic              ext_rst_b;
  logic              ext_next_cpu_q;
  logic              ext_ring_done;
  logic [DATA_W-1:0] ext_cpu_index;
  logic [MSG_W-1:0]  ext_cpu_msg;
  core_state_e       core_state;
  logic              core_read_q;
  logic              core_write_q;
  logic [DATA_W-1:0] bus_addr;
  logic [DATA_W-1:0] bus_data;
  logic              msg_credit;
  logic              core_next_state;
  logic              core_rst;
  logic              ext_rst_e;
  logic              ext_dispatcher_q;
  logic              disp_online;
  logic              ext_next_cpu_e;
  logic              ext_read_q;
  logic              ext_write_q;
  logic [DATA_W-1:0] base_addr;
  logic [DATA_W-1:0] base_addr_data;
  logic              msg_valid;
  logic [MSG_W-1:0]  msg_code;
  logic [DATA_W-1:0] msg_index;
  ind_rel_e          cpu_ind_rel;

  logic [31:0]       lfsr_state;
  logic [DATA_W-1:0] own_exp;
  logic [MSG_W-1:0]  seen_code [$];
  logic [DATA_W-1:0] seen_index [$];

  bridge_top #(
    .CREDITS (2)
  ) DUT (
    .clk              (clk),
    .ext_rst_b        (ext_rst_b),
    .ext_next_cpu_q   (ext_next_cpu_q),
    .ext_ring_done    (ext_ring_done),
    .ext_cpu_index    (ext_cpu_index),
    .ext_cpu_msg      (ext_cpu_msg),
    .core_state       (core_state),
    .core_read_q      (core_read_q),
    .core_write_q     (core_write_q),
    .bus_addr         (bus_addr),
    .bus_data         (bus_data),
    .msg_credit       (msg_credit),
    .core_next_state  (core_next_state),
    .core_rst         (core_rst),
    .ext_rst_e        (ext_rst_e),
    .ext_dispatcher_q (ext_dispatcher_q),
    .disp_online      (disp_online),
    .ext_next_cpu_e   (ext_next_cpu_e),
    .ext_read_q       (ext_read_q),
    .ext_write_q      (ext_write_q),
    .base_addr        (base_addr),
    .base_addr_data   (base_addr_data),
    .msg_valid        (msg_valid),
    .msg_code         (msg_code),
    .msg_index        (msg_index),
    .cpu_ind_rel      (cpu_ind_rel)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // outgoing messages collected mid cycle
  always @(negedge clk) begin
    if (msg_valid) begin
      seen_code.push_back(msg_code);
      seen_index.push_back(msg_index);
    end
  end

  // fibonacci lfsr, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int i = 0; i < n; i++) begin
      fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      val        = {val[30:0], fb};
    end
    return val;
  endfunction

  task automatic stop_failed();
    $display("Test FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check(logic [63:0] act, logic [63:0] exp, string what);
    if (act !== exp) begin
      $display("** Error @ %0t ns: %s, got %0h expected %0h", $time, what, act, exp);
      stop_failed();
    end
  endtask

  // edge, then settle before looking or driving
  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  task automatic return_credit();
    msg_credit = 1'b1;
    tick();
    msg_credit = 1'b0;
  endtask

  task automatic wait_msg(ring_msg_e code, logic [DATA_W-1:0] idx);
    int n;
    n = 0;
    while (seen_code.size() == 0) begin
      if (n == MSG_WAIT) begin
        $display("no outgoing message arrived within %0d cycles", MSG_WAIT);
        stop_failed();
      end
      tick();
      n++;
    end
    check(64'(seen_code.pop_front()), 64'(code), "message code");
    check(64'(seen_index.pop_front()), 64'(idx), "message index");
  endtask

  // one cycle grant pulse on the ring
  task automatic pulse_grant(logic [DATA_W-1:0] idx);
    ext_next_cpu_q = 1'b1;
    ext_cpu_index  = idx;
    tick();
    ext_next_cpu_q = 1'b0;
  endtask

  task automatic pulse_done(logic [DATA_W-1:0] idx, ring_msg_e code);
    ext_ring_done = 1'b1;
    ext_cpu_index = idx;
    ext_cpu_msg   = code;
    tick();
    ext_ring_done = 1'b0;
    ext_cpu_msg   = MSG_VOID;
    // ctrl acts one cycle after the snoop register
    tick();
  endtask

  task automatic expect_rel(logic [DATA_W-1:0] idx, ind_rel_e rel);
    pulse_grant(idx);
    check(64'(cpu_ind_rel), 64'(rel), "grant relation");
  endtask

  task automatic reset_sequence();
    ext_rst_b = 1'b1;
    repeat (16) @(posedge clk);
    #1;
    ext_rst_b = 1'b0;
    for (int k = 1; k <= 6; k++) begin
      tick();
      check(64'(ext_rst_e), 64'(k == 4), "ext_rst_e in reset sequence");
      check(64'(core_rst), 64'(k == 4), "core_rst in reset sequence");
      check(64'(ext_dispatcher_q), 64'(k >= 5), "ext_dispatcher_q in reset sequence");
    end
    wait_msg(MSG_RESET, own_exp);
    return_credit();
  endtask

  task automatic start_grant(logic [DATA_W-1:0] addr, logic [DATA_W-1:0] data);
    core_state = ST_WAIT_FOR_START;
    bus_addr   = addr;
    bus_data   = data;
    pulse_grant(own_exp);
    tick();
    check(64'(base_addr), 64'(addr + 32'd16), "base_addr");
    if (data == '0) begin
      check(64'(base_addr_data), 64'(addr + 32'd16), "base_addr_data, zero data");
    end else begin
      check(64'(base_addr_data), 64'(data + 32'd16), "base_addr_data");
    end
    check(64'(core_next_state), 64'(1), "core_next_state pulse");
    check(64'(ext_next_cpu_e), 64'(1), "ext_next_cpu_e pulse on start");
    check(64'(disp_online), 64'(1), "disp_online after start");
    wait_msg(MSG_START, own_exp);
    return_credit();
  endtask

  task automatic start_thread();
    start_grant(rand_bits(32), rand_bits(32) | 32'h1);
    start_grant(rand_bits(32), '0);
  endtask

  task automatic grant_relation();
    core_state = ST_ALU_BEGIN;
    expect_rel(own_exp - 32'd1 - (rand_bits(16) % 500), REL_LOWER);
    expect_rel(own_exp + 32'd1 + (rand_bits(16) % 500), REL_HIGHER);
    expect_rel(own_exp, REL_SELF);
    // done clears the relation
    ext_ring_done = 1'b1;
    ext_cpu_msg   = MSG_VOID;
    tick();
    ext_ring_done = 1'b0;
    check(64'(cpu_ind_rel), 64'(REL_NONE), "relation after done");
  endtask

  task automatic index_tracking();
    logic [DATA_W-1:0] other;
    core_state = ST_ALU_BEGIN;
    // nonactive core starts, active own index moves up
    other = {1'b0, 31'(32'd1 + (rand_bits(16) % 5000))};
    pulse_done(other, MSG_START);
    own_exp = own_exp + 32'd1;
    expect_rel(own_exp, REL_SELF);
    expect_rel(own_exp - 32'd1, REL_LOWER);
    // lower active core ends, own index moves down
    other = {1'b1, 31'(rand_bits(16) % 500)};
    pulse_done(other, MSG_END);
    own_exp = own_exp - 32'd1;
    expect_rel(own_exp, REL_SELF);
    expect_rel(own_exp + 32'd1, REL_HIGHER);
    // END message carries the tracked index
    core_state = ST_FINISH_BEGIN;
    pulse_grant(own_exp);
    tick();
    core_state = ST_ALU_BEGIN;
    wait_msg(MSG_END, own_exp);
    return_credit();
  endtask

  task automatic request_forwarding();
    core_state = ST_READ_SRC0;
    pulse_grant(own_exp);
    tick();
    check(64'(disp_online), 64'(1), "online before requests");
    core_read_q  = 1'b1;
    core_write_q = 1'b1;
    repeat (2) begin
      tick();
      check(64'(ext_read_q), 64'(1), "ext_read_q while online");
      check(64'(ext_write_q), 64'(0), "ext_write_q in read state");
      check(64'(ext_next_cpu_e), 64'(1), "ext_next_cpu_e on online request");
    end
    // idle cycle takes the bridge offline
    core_read_q  = 1'b0;
    core_write_q = 1'b0;
    tick();
    check(64'(disp_online), 64'(0), "offline after idle cycle");
    check(64'(ext_next_cpu_e), 64'(0), "ext_next_cpu_e in idle cycle");
    core_read_q  = 1'b1;
    core_write_q = 1'b1;
    repeat (2) begin
      tick();
      check(64'(ext_read_q), 64'(0), "ext_read_q while offline");
      check(64'(ext_write_q), 64'(0), "ext_write_q while offline");
      check(64'(ext_next_cpu_e), 64'(0), "ext_next_cpu_e while offline");
    end
    core_read_q  = 1'b0;
    core_write_q = 1'b0;
    core_state   = ST_ALU_BEGIN;
  endtask

  task automatic credit_backpressure();
    ring_msg_e order [4];
    order = '{MSG_END, MSG_START, MSG_END, MSG_START};
    // four pushes, only two credits
    for (int i = 0; i < 4; i++) begin
      core_state = (order[i] == MSG_END) ? ST_FINISH_BEGIN : ST_WAIT_FOR_START;
      pulse_grant(own_exp);
      tick();
    end
    core_state = ST_ALU_BEGIN;
    repeat (8) tick();
    check(64'(seen_code.size()), 64'(2), "messages sent without credit return");
    wait_msg(order[0], own_exp);
    wait_msg(order[1], own_exp);
    repeat (6) tick();
    check(64'(seen_code.size()), 64'(0), "message sent with no credit");
    return_credit();
    wait_msg(order[2], own_exp);
    repeat (6) tick();
    check(64'(seen_code.size()), 64'(0), "extra message after one credit");
    return_credit();
    wait_msg(order[3], own_exp);
  endtask

  // watchdog
  initial begin
    #((TEST_CYCLES + MARGIN) * 10);
    $display("watchdog expired, the tests did not finish in time");
    stop_failed();
  end

  initial begin
    lfsr_state     = 32'hb0b4;
    ext_rst_b      = 1'b1;
    ext_next_cpu_q = 1'b0;
    ext_ring_done  = 1'b0;
    ext_cpu_msg    = MSG_VOID;
    core_state     = ST_WAIT_FOR_START;
    core_read_q    = 1'b0;
    core_write_q   = 1'b0;
    bus_addr       = '0;
    bus_data       = '0;
    msg_credit     = 1'b0;
    // active own index with room above and below
    own_exp        = {1'b1, 31'(32'd1000 + (rand_bits(20) % 100000))};
    ext_cpu_index  = own_exp;

    reset_sequence();
    start_thread();
    grant_relation();
    index_tracking();
    request_forwarding();
    credit_backpressure();

    if (DUT.u_sender.u_sva.fail_cnt == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule
